// File: src/ship_pkg.sv
package ship_pkg;

  typedef logic [10:0] coord_t;
  typedef logic [11:0] rgb_t;
  typedef logic [1:0]  lives_t;

  // one pixel of the timing stream
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;
  } vga_t;

  localparam rgb_t SHIP_RGB      = 12'h0_f_0;
  localparam rgb_t SHIP_DEAD_RGB = 12'h8_8_8;
  localparam rgb_t MISSILE_RGB   = 12'hf_f_0;
  localparam rgb_t HEART_RGB     = 12'hf_0_4;

  localparam coord_t SHIP_W       = 11'd16;
  localparam coord_t SHIP_H       = 11'd8;
  localparam coord_t MISSILE_W    = 11'd2;
  localparam coord_t MISSILE_H    = 11'd4;
  localparam coord_t HEART_SIZE   = 11'd4;
  localparam coord_t HEART_PITCH  = 11'd6;
  localparam coord_t SHIP_STEP    = 11'd2;
  localparam coord_t MISSILE_STEP = 11'd3;

  localparam lives_t LIVES_INIT = 2'd3;

  // point inside a box, right and bottom edges excluded
  function automatic logic in_box(input coord_t x, input coord_t y, input coord_t bx,
                                  input coord_t by, input coord_t bw, input coord_t bh);
    return (x >= bx) && (x < coord_t'(bx + bw)) && (y >= by) && (y < coord_t'(by + bh));
  endfunction

endpackage

// File: src/ship_move_ctl.sv
`timescale 1ns/1ns

module ship_move_ctl
  import ship_pkg::*;
#(
  parameter coord_t SCREEN_W    = 11'd640,
  parameter coord_t RESET_X_POS = 11'd312
) (
  input  logic   pclk,
  input  logic   arst_n_i,
  input  logic   left_i,
  input  logic   right_i,
  input  logic   vblnk_i,
  input  logic   dead_i,
  output logic   frame_tick_o,
  output coord_t ship_x_o
);

  localparam coord_t MAX_X = coord_t'(SCREEN_W - SHIP_W);

  logic vblnk_q;

  // frame start on the rising edge of vblnk
  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vblnk_q      <= 1'b0;
      frame_tick_o <= 1'b0;
    end else begin
      vblnk_q      <= vblnk_i;
      frame_tick_o <= vblnk_i & ~vblnk_q;
    end
  end

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ship_x_o <= RESET_X_POS;
    end else if (frame_tick_o && !dead_i) begin
      if (left_i && !right_i) begin
        ship_x_o <= (ship_x_o < SHIP_STEP) ? '0 : ship_x_o - SHIP_STEP;
      end else if (right_i && !left_i) begin
        // clamp at the right edge
        ship_x_o <= (ship_x_o + SHIP_STEP > MAX_X) ? MAX_X : ship_x_o + SHIP_STEP;
      end
    end
  end

endmodule

// File: src/missile_ctl.sv
`timescale 1ns/1ns

module missile_ctl
  import ship_pkg::*;
#(
  parameter coord_t SHIP_Y = 11'd440
) (
  input  logic   pclk,
  input  logic   arst_n_i,
  input  logic   frame_tick_i,
  input  logic   fire_i,
  input  logic   dead_i,
  input  coord_t ship_x_i,
  output coord_t missile_x_o,
  output coord_t missile_y_o,
  output logic   missile_on_o
);

  typedef enum logic {
    IDLE,
    FLYING
  } state_t;

  state_t state;

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state       <= IDLE;
      missile_x_o <= '0;
      missile_y_o <= '0;
    end else if (frame_tick_i) begin
      case (state)
        IDLE: begin
          if (fire_i && !dead_i) begin
            // spawn just above the ship's centre
            missile_x_o <= ship_x_i + (SHIP_W >> 1);
            missile_y_o <= SHIP_Y - MISSILE_H;
            state       <= FLYING;
          end
        end
        FLYING: begin
          // next step would cross the top line
          if (missile_y_o < MISSILE_STEP) begin
            state <= IDLE;
          end else begin
            missile_y_o <= missile_y_o - MISSILE_STEP;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign missile_on_o = (state == FLYING);

endmodule

// File: src/hit_detect.sv
`timescale 1ns/1ns

module hit_detect
  import ship_pkg::*;
#(
  parameter coord_t SHIP_Y = 11'd440
) (
  input  logic         pclk,
  input  logic         arst_n_i,
  input  coord_t       ship_x_i,
  input  logic         dead_i,
  input  coord_t [4:0] en_x_i,
  input  coord_t [4:0] en_y_i,
  output logic         hit_o
);

  logic [4:0] point_in;
  logic       any_hit;
  logic       any_q;
  logic       any_d;

  // five enemy missile points against the ship box
  always_comb begin
    for (int i = 0; i < 5; i++) begin
      point_in[i] = in_box(en_x_i[i], en_y_i[i], ship_x_i, SHIP_Y, SHIP_W, SHIP_H);
    end
  end

  assign any_hit = |point_in;

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      any_q <= 1'b0;
      any_d <= 1'b0;
      hit_o <= 1'b0;
    end else begin
      any_q <= any_hit;
      any_d <= any_q;
      // one pulse per contact, none while the ship is down
      hit_o <= any_q & ~any_d & ~dead_i;
    end
  end

endmodule

// File: src/life_tracker.sv
`timescale 1ns/1ns

module life_tracker
  import ship_pkg::*;
#(
  parameter int DEAD_FRAMES = 60
) (
  input  logic   pclk,
  input  logic   arst_n_i,
  input  logic   hit_i,
  input  logic   frame_tick_i,
  output lives_t lives_o,
  output logic   dead_o,
  output logic   game_over_o
);

  localparam int CW = $clog2(DEAD_FRAMES + 1);

  logic          dead_q;
  logic [CW-1:0] dead_cnt;

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lives_o     <= LIVES_INIT;
      dead_q      <= 1'b0;
      dead_cnt    <= '0;
      game_over_o <= 1'b0;
    end else if (hit_i && !dead_o && lives_o != '0) begin
      lives_o  <= lives_o - 2'd1;
      dead_q   <= 1'b1;
      dead_cnt <= CW'(DEAD_FRAMES);
      // last life gone
      if (lives_o == 2'd1) begin
        game_over_o <= 1'b1;
      end
    end else if (dead_q && frame_tick_i) begin
      dead_cnt <= dead_cnt - 1'b1;
      if (dead_cnt == CW'(1)) begin
        dead_q <= 1'b0;
      end
    end
  end

  // game over keeps the ship down until reset
  assign dead_o = dead_q | game_over_o;

endmodule

// File: src/sprite_overlay.sv
`timescale 1ns/1ns

module sprite_overlay
  import ship_pkg::*;
#(
  parameter coord_t SCREEN_W   = 11'd640,
  parameter coord_t SCREEN_H   = 11'd480,
  parameter coord_t SHIP_Y     = 11'd440,
  parameter coord_t XPOS_LIVES = 11'd8,
  parameter coord_t YPOS_LIVES = 11'd8
) (
  input  logic   pclk,
  input  logic   arst_n_i,
  input  vga_t   vga_i,
  input  coord_t ship_x_i,
  input  logic   dead_i,
  input  coord_t missile_x_i,
  input  coord_t missile_y_i,
  input  logic   missile_on_i,
  input  lives_t lives_i,
  output vga_t   vga_o
);

  logic       on_screen;
  logic       in_ship;
  logic       in_missile;
  logic [2:0] in_heart;

  vga_t       vga_q;
  logic       in_ship_q;
  logic       in_missile_q;
  logic       in_heart_q;
  logic       dead_q;

  assign on_screen = (vga_i.hcount < SCREEN_W) && (vga_i.vcount < SCREEN_H);

  always_comb begin
    coord_t heart_y;
    in_ship    = on_screen &&
                 in_box(vga_i.hcount, vga_i.vcount, ship_x_i, SHIP_Y, SHIP_W, SHIP_H);
    in_missile = on_screen && missile_on_i &&
                 in_box(vga_i.hcount, vga_i.vcount, missile_x_i, missile_y_i,
                        MISSILE_W, MISSILE_H);
    // hearts stacked downwards, one per remaining life
    for (int k = 0; k < 3; k++) begin
      heart_y     = YPOS_LIVES + coord_t'(k) * HEART_PITCH;
      in_heart[k] = on_screen && (lives_t'(k) < lives_i) &&
                    in_box(vga_i.hcount, vga_i.vcount, XPOS_LIVES, heart_y,
                           HEART_SIZE, HEART_SIZE);
    end
  end

  // stage 1
  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vga_q        <= '0;
      in_ship_q    <= 1'b0;
      in_missile_q <= 1'b0;
      in_heart_q   <= 1'b0;
      dead_q       <= 1'b0;
    end else begin
      vga_q        <= vga_i;
      in_ship_q    <= in_ship;
      in_missile_q <= in_missile;
      in_heart_q   <= |in_heart;
      dead_q       <= dead_i;
    end
  end

  // stage 2, colour priority
  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vga_o <= '0;
    end else begin
      vga_o <= vga_q;
      if (!vga_q.hblnk && !vga_q.vblnk) begin
        if (in_missile_q) begin
          vga_o.rgb <= MISSILE_RGB;
        end else if (in_ship_q) begin
          vga_o.rgb <= dead_q ? SHIP_DEAD_RGB : SHIP_RGB;
        end else if (in_heart_q) begin
          vga_o.rgb <= HEART_RGB;
        end
      end
    end
  end

endmodule

// File: src/draw_ship.sv
`timescale 1ns/1ns

module draw_ship
  import ship_pkg::*;
#(
  parameter coord_t SCREEN_W    = 11'd640,
  parameter coord_t SCREEN_H    = 11'd480,
  parameter coord_t SHIP_Y      = 11'd440,
  parameter coord_t RESET_X_POS = 11'd312,
  parameter coord_t XPOS_LIVES  = 11'd8,
  parameter coord_t YPOS_LIVES  = 11'd8,
  parameter int     DEAD_FRAMES = 60
) (
  input  logic         pclk,
  input  logic         arst_n_i,
  input  logic         left_i,
  input  logic         right_i,
  input  logic         fire_i,
  input  coord_t [4:0] en_x_i,
  input  coord_t [4:0] en_y_i,
  input  vga_t         vga_i,
  output vga_t         vga_o,
  output coord_t       ship_x_o,
  output coord_t       missile_x_o,
  output coord_t       missile_y_o,
  output logic         missile_on_o,
  output logic         ship_down_o,
  output lives_t       lives_o,
  output logic         game_over_o
);

  logic frame_tick;
  logic hit;

  ship_move_ctl #(
    .SCREEN_W   (SCREEN_W),
    .RESET_X_POS(RESET_X_POS)
  ) u_ship_move_ctl (
    .pclk        (pclk),
    .arst_n_i    (arst_n_i),
    .left_i      (left_i),
    .right_i     (right_i),
    .vblnk_i     (vga_i.vblnk),
    .dead_i      (ship_down_o),
    .frame_tick_o(frame_tick),
    .ship_x_o    (ship_x_o)
  );

  missile_ctl #(
    .SHIP_Y(SHIP_Y)
  ) u_missile_ctl (
    .pclk        (pclk),
    .arst_n_i    (arst_n_i),
    .frame_tick_i(frame_tick),
    .fire_i      (fire_i),
    .dead_i      (ship_down_o),
    .ship_x_i    (ship_x_o),
    .missile_x_o (missile_x_o),
    .missile_y_o (missile_y_o),
    .missile_on_o(missile_on_o)
  );

  hit_detect #(
    .SHIP_Y(SHIP_Y)
  ) u_hit_detect (
    .pclk    (pclk),
    .arst_n_i(arst_n_i),
    .ship_x_i(ship_x_o),
    .dead_i  (ship_down_o),
    .en_x_i  (en_x_i),
    .en_y_i  (en_y_i),
    .hit_o   (hit)
  );

  life_tracker #(
    .DEAD_FRAMES(DEAD_FRAMES)
  ) u_life_tracker (
    .pclk        (pclk),
    .arst_n_i    (arst_n_i),
    .hit_i       (hit),
    .frame_tick_i(frame_tick),
    .lives_o     (lives_o),
    .dead_o      (ship_down_o),
    .game_over_o (game_over_o)
  );

  sprite_overlay #(
    .SCREEN_W  (SCREEN_W),
    .SCREEN_H  (SCREEN_H),
    .SHIP_Y    (SHIP_Y),
    .XPOS_LIVES(XPOS_LIVES),
    .YPOS_LIVES(YPOS_LIVES)
  ) u_sprite_overlay (
    .pclk        (pclk),
    .arst_n_i    (arst_n_i),
    .vga_i       (vga_i),
    .ship_x_i    (ship_x_o),
    .dead_i      (ship_down_o),
    .missile_x_i (missile_x_o),
    .missile_y_i (missile_y_o),
    .missile_on_i(missile_on_o),
    .lives_i     (lives_o),
    .vga_o       (vga_o)
  );

endmodule

// File: dv/draw_ship_props.sv
`timescale 1ns/1ns

module draw_ship_props
  import ship_pkg::*;
#(
  parameter coord_t SCREEN_W    = 11'd640,
  parameter coord_t SHIP_Y      = 11'd440,
  parameter coord_t RESET_X_POS = 11'd312,
  parameter coord_t XPOS_LIVES  = 11'd8,
  parameter coord_t YPOS_LIVES  = 11'd8,
  parameter int     DEAD_FRAMES = 60
) (
  input logic   pclk,
  input logic   arst_n_i,
  input logic   left_i,
  input logic   right_i,
  input logic   fire_i,
  input vga_t   vga_i,
  input vga_t   vga_o,
  input coord_t ship_x_o,
  input coord_t missile_x_o,
  input coord_t missile_y_o,
  input logic   missile_on_o,
  input logic   ship_down_o,
  input lives_t lives_o,
  input logic   game_over_o
);

  int unsigned fails = 0;

  logic   vb_q;
  logic   tick_q;
  coord_t ref_x;
  int     nx;
  int     down_ticks;
  coord_t dy;
  rgb_t   exp_rgb;

  // clamped next ship position from the buttons
  always_comb begin
    nx = int'(ref_x) + (right_i ? int'(SHIP_STEP) : 0) - (left_i ? int'(SHIP_STEP) : 0);
    if (nx < 0) begin
      nx = 0;
    end
    if (nx > int'(SCREEN_W - SHIP_W)) begin
      nx = int'(SCREEN_W - SHIP_W);
    end
  end

  // model state stepped on vblnk edges
  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vb_q       <= 1'b0;
      tick_q     <= 1'b0;
      ref_x      <= RESET_X_POS;
      down_ticks <= 0;
    end else begin
      vb_q       <= vga_i.vblnk;
      tick_q     <= vga_i.vblnk && !vb_q;
      down_ticks <= ship_down_o ? down_ticks + int'(tick_q) : 0;
      if (tick_q && !ship_down_o) begin
        ref_x <= coord_t'(nx);
      end
    end
  end

  // expected colour of the pixel now entering the pipeline
  always_comb begin
    dy      = coord_t'(vga_i.vcount - YPOS_LIVES);
    exp_rgb = vga_i.rgb;
    if (!vga_i.hblnk && !vga_i.vblnk) begin
      if (missile_on_o && coord_t'(vga_i.hcount - missile_x_o) < MISSILE_W &&
          coord_t'(vga_i.vcount - missile_y_o) < MISSILE_H) begin
        exp_rgb = MISSILE_RGB;
      end else if (coord_t'(vga_i.hcount - ship_x_o) < SHIP_W &&
                   coord_t'(vga_i.vcount - SHIP_Y) < SHIP_H) begin
        exp_rgb = ship_down_o ? SHIP_DEAD_RGB : SHIP_RGB;
      end else if (coord_t'(vga_i.hcount - XPOS_LIVES) < HEART_SIZE &&
                   dy < HEART_PITCH * lives_o && dy % HEART_PITCH < HEART_SIZE) begin
        exp_rgb = HEART_RGB;
      end
    end
  end

  a_reset: assert property (@(posedge pclk) !arst_n_i |-> ship_x_o == RESET_X_POS &&
                            !missile_on_o && lives_o == LIVES_INIT && !ship_down_o &&
                            !game_over_o && vga_o == '0)
    else begin
      fails++;
      $error("outputs not at their reset values");
    end

  a_ship: assert property (@(posedge pclk) disable iff (!arst_n_i) ship_x_o == ref_x)
    else begin
      fails++;
      $error("ship_x_o %0d differs from model %0d", ship_x_o, ref_x);
    end

  a_fire: assert property (@(posedge pclk) disable iff (!arst_n_i)
                           tick_q && fire_i && !ship_down_o && !missile_on_o |=> missile_on_o)
    else begin
      fails++;
      $error("fire at a frame start did not launch the missile");
    end

  a_launch: assert property (@(posedge pclk) disable iff (!arst_n_i)
                             $rose(missile_on_o) |-> $past(fire_i && tick_q && !ship_down_o) &&
                             missile_x_o == coord_t'($past(ship_x_o) + SHIP_W / 2) &&
                             missile_y_o == coord_t'(SHIP_Y - MISSILE_H))
    else begin
      fails++;
      $error("missile launched at the wrong time or place");
    end

  a_climb: assert property (@(posedge pclk) disable iff (!arst_n_i)
                            missile_on_o && $past(missile_on_o) |->
                            missile_x_o == $past(missile_x_o) &&
                            ($past(tick_q) ?
                             $past(missile_y_o) >= MISSILE_STEP &&
                             missile_y_o == coord_t'($past(missile_y_o) - MISSILE_STEP) :
                             missile_y_o == $past(missile_y_o)))
    else begin
      fails++;
      $error("missile did not climb by one step per frame");
    end

  a_leave: assert property (@(posedge pclk) disable iff (!arst_n_i)
                            $fell(missile_on_o) |-> $past(tick_q) &&
                            $past(missile_y_o) < MISSILE_STEP)
    else begin
      fails++;
      $error("missile switched off before reaching the top");
    end

  a_lives: assert property (@(posedge pclk) disable iff (!arst_n_i)
                            lives_o != $past(lives_o) |->
                            lives_o == lives_t'($past(lives_o) - 1) && $rose(ship_down_o))
    else begin
      fails++;
      $error("life count changed without a fresh hit");
    end

  a_hold: assert property (@(posedge pclk) disable iff (!arst_n_i)
                           $fell(ship_down_o) |-> down_ticks == DEAD_FRAMES && !game_over_o)
    else begin
      fails++;
      $error("ship down for %0d frames", down_ticks);
    end

  a_over: assert property (@(posedge pclk) disable iff (!arst_n_i)
                           lives_o == '0 |-> game_over_o && ship_down_o)
    else begin
      fails++;
      $error("no lives left but game over not held");
    end

  a_timing: assert property (@(posedge pclk) disable iff (!arst_n_i)
                             vga_o[37:12] == $past(vga_i[37:12], 2))
    else begin
      fails++;
      $error("pixel timing fields not delayed by two cycles");
    end

  a_pixel: assert property (@(posedge pclk) disable iff (!arst_n_i)
                            vga_o.rgb == $past(exp_rgb, 2))
    else begin
      fails++;
      $error("pixel colour %h, model %h", vga_o.rgb, $past(exp_rgb, 2));
    end

endmodule

bind draw_ship draw_ship_props #(
  .SCREEN_W   (SCREEN_W),
  .SHIP_Y     (SHIP_Y),
  .RESET_X_POS(RESET_X_POS),
  .XPOS_LIVES (XPOS_LIVES),
  .YPOS_LIVES (YPOS_LIVES),
  .DEAD_FRAMES(DEAD_FRAMES)
) u_props (.*);

// File: dv/tb_draw_ship.sv
`timescale 1ns/1ns

module tb_draw_ship
  import ship_pkg::*;
();

  localparam coord_t SCREEN_W     = 11'd64;
  localparam coord_t SCREEN_H     = 11'd48;
  localparam coord_t SHIP_Y       = 11'd36;
  localparam int     H_TOTAL      = 80;
  localparam int     V_TOTAL      = 52;
  localparam int     FRAME_CYCLES = H_TOTAL * V_TOTAL;

  logic         pclk = 1'b0;
  logic         arst_n_i;
  logic         left_i;
  logic         right_i;
  logic         fire_i;
  coord_t [4:0] en_x_i;
  coord_t [4:0] en_y_i;
  vga_t         vga_i;
  vga_t         vga_o;
  coord_t       ship_x;
  coord_t       missile_x;
  coord_t       missile_y;
  logic         missile_on;
  logic         ship_down;
  lives_t       lives;
  logic         game_over;
  coord_t       hc;
  coord_t       vc;
  int           errors   = 0;
  int           timeouts = 0;

  always #2 pclk = ~pclk;

  draw_ship #(
    .SCREEN_W   (SCREEN_W),
    .SCREEN_H   (SCREEN_H),
    .SHIP_Y     (SHIP_Y),
    .RESET_X_POS(11'd24),
    .XPOS_LIVES (11'd2),
    .YPOS_LIVES (11'd2),
    .DEAD_FRAMES(4)
  ) uut (
    .pclk        (pclk),
    .arst_n_i    (arst_n_i),
    .left_i      (left_i),
    .right_i     (right_i),
    .fire_i      (fire_i),
    .en_x_i      (en_x_i),
    .en_y_i      (en_y_i),
    .vga_i       (vga_i),
    .vga_o       (vga_o),
    .ship_x_o    (ship_x),
    .missile_x_o (missile_x),
    .missile_y_o (missile_y),
    .missile_on_o(missile_on),
    .ship_down_o (ship_down),
    .lives_o     (lives),
    .game_over_o (game_over)
  );

  // tiny raster blanked outside the visible area
  always @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hc    <= '0;
      vc    <= '0;
      vga_i <= '0;
    end else begin
      hc <= (int'(hc) == H_TOTAL - 1) ? '0 : hc + 11'd1;
      if (int'(hc) == H_TOTAL - 1) begin
        vc <= (int'(vc) == V_TOTAL - 1) ? '0 : vc + 11'd1;
      end
      vga_i.hcount <= hc;
      vga_i.vcount <= vc;
      vga_i.hblnk  <= hc >= SCREEN_W;
      vga_i.vblnk  <= vc >= SCREEN_H;
      vga_i.hsync  <= hc >= 11'd68 && hc < 11'd72;
      vga_i.vsync  <= vc == 11'd49;
      vga_i.rgb    <= rgb_t'($urandom);
    end
  end

  task automatic wait_frames(input int n);
    int   seen;
    int   cycles;
    logic vb_prev;
    seen    = 0;
    cycles  = 0;
    vb_prev = vga_i.vblnk;
    while (seen < n && cycles < (n + 1) * FRAME_CYCLES) begin
      @(posedge pclk);
      cycles++;
      if (vga_i.vblnk && !vb_prev) begin
        seen++;
      end
      vb_prev = vga_i.vblnk;
    end
    if (seen < n) begin
      timeouts++;
      $display("timeout after %0d of %0d frames", seen, n);
    end
  endtask

  task automatic wait_down(input logic level);
    int cycles;
    cycles = 0;
    while (ship_down !== level && cycles < 8 * FRAME_CYCLES) begin
      @(posedge pclk);
      cycles++;
    end
    if (ship_down !== level) begin
      timeouts++;
      $display("timeout waiting for ship_down_o to become %0b", level);
    end
  endtask

  // park an enemy point on the ship and retouch it while down
  task automatic strike(input lives_t want);
    en_x_i[2] <= ship_x + 11'd4;
    en_y_i[2] <= SHIP_Y + 11'd2;
    wait_down(1'b1);
    en_y_i[2] <= '0;
    @(posedge pclk);
    en_y_i[2] <= SHIP_Y + 11'd2;
    right_i   <= 1'b1;
    fire_i    <= 1'b1;
    wait_frames(2);
    en_y_i[2] <= '0;
    right_i   <= 1'b0;
    fire_i    <= 1'b0;
    if (lives !== want) begin
      errors++;
      $display("mismatch strike lives: expected %0d actual %0d", want, lives);
    end
    if (want != 2'd0) begin
      wait_down(1'b0);
    end
  endtask

  initial begin
    void'($urandom(10180));
    arst_n_i = 1'b1;
    left_i   = 1'b0;
    right_i  = 1'b0;
    fire_i   = 1'b0;
    en_x_i   = '0;
    en_y_i   = '0;
    vga_i    = '0;
    #1 arst_n_i = 1'b0;
    repeat (4) @(posedge pclk);
    arst_n_i <= 1'b1;

    // into both clamps, then both buttons away from the edges
    right_i <= 1'b1;
    wait_frames(16);
    right_i <= 1'b0;
    left_i  <= 1'b1;
    wait_frames(28);
    left_i  <= 1'b0;
    right_i <= 1'b1;
    wait_frames(5);
    left_i  <= 1'b1;
    wait_frames(3);
    left_i  <= 1'b0;
    right_i <= 1'b0;

    // fire held through part of the flight
    fire_i <= 1'b1;
    wait_frames(6);
    fire_i <= 1'b0;
    wait_frames(12);

    strike(2'd2);
    strike(2'd1);
    strike(2'd0);
    if (game_over !== 1'b1) begin
      errors++;
      $display("mismatch game over: expected 1 actual %0b", game_over);
    end
    wait_frames(2);

    $display("assertion failures %0d, mismatches %0d, timeouts %0d",
             uut.u_props.fails, errors, timeouts);
    if (uut.u_props.fails == 0 && errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
src/ship_pkg.sv
src/ship_move_ctl.sv
src/missile_ctl.sv
src/hit_detect.sv
src/life_tracker.sv
src/sprite_overlay.sv
src/draw_ship.sv
dv/draw_ship_props.sv
dv/tb_draw_ship.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_draw_ship \
    -o sim_tb > build.log 2>&1 &&
  ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 &&
  ! grep -q ">>> FAIL" sim.log ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }
echo "simulation passed"
